/* include/rv_pipe_defines.svh */
`ifndef RV_PIPE_DEFINES_SVH
`define RV_PIPE_DEFINES_SVH

// data and address width
`define XLEN 32

// register index width
`define REG_AW 5

// architectural register count
`define NUM_REGS 32

// addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif

/* verilog/rv_pipe_pkg.sv */
package rv_pipe_pkg;

    // rv32i major opcodes seen by the pipeline
    typedef enum logic [6:0] {
        // all-zero opcode is illegal in rv32i, so bubbles use it
        NOP_OP = 7'b0000000,
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    // alu function after funct3/funct7/opcode are combined
    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        AND    = 4'd2,
        OR     = 4'd3,
        XOR    = 4'd4,
        SLT    = 4'd5,
        SLL    = 4'd6,
        SRL    = 4'd7,
        // lui result is the immediate itself
        PASS_B = 4'd8
    } alu_op_e;

endpackage

/* verilog/rv_regfile.sv */
`timescale 1ns/1ns
`include "rv_pipe_defines.svh"

module rv_regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [`REG_AW-1:0] rs1_addr,
    input  logic [`REG_AW-1:0] rs2_addr,
    output logic [`XLEN-1:0]   rs1_data,
    output logic [`XLEN-1:0]   rs2_data,
    input  logic               wr_en,
    input  logic [`REG_AW-1:0] wr_addr,
    input  logic [`XLEN-1:0]   wr_data
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    // x0 reads as zero and a same-cycle write is bypassed to the reader
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_AW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (wr_en && (wr_addr == addr)) begin
            return wr_data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

endmodule

/* verilog/rv_decode.sv */
`timescale 1ns/1ns
`include "rv_pipe_defines.svh"

module rv_decode (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 instr_valid,
    input  logic [`XLEN-1:0]     instr,
    input  logic [`XLEN-1:0]     instr_pc,
    input  logic                 stall,
    input  logic                 redirect,
    input  logic [`XLEN-1:0]     rs1_data,
    input  logic [`XLEN-1:0]     rs2_data,
    input  logic [`REG_AW-1:0]   ex_rd,
    input  logic                 ex_wr_n,
    input  logic [`REG_AW-1:0]   wb_rd,
    input  logic                 wb_valid,
    output logic                 instr_ready,
    output logic [`REG_AW-1:0]   rs1_addr,
    output logic [`REG_AW-1:0]   rs2_addr,
    output logic                 interlock,
    output logic [`XLEN-1:0]     pc,
    output logic [`XLEN-1:0]     pc4,
    output logic [`XLEN-1:0]     data1,
    output logic [`XLEN-1:0]     data2,
    output logic [6:0]           funct7,
    output logic [2:0]           funct3,
    output logic [`REG_AW-1:0]   rs2,
    output logic [`REG_AW-1:0]   rd,
    output rv_pipe_pkg::opcode_e opcode,
    output logic [`XLEN-1:0]     imm,
    output logic                 wr_reg_n
);
    import rv_pipe_pkg::*;

    opcode_e          op_dec;
    logic             uses_rs1;
    logic             uses_rs2;
    logic             writes_rd;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_j;
    logic             rs1_busy;
    logic             rs2_busy;
    logic             squash;
    logic             squash_q;
    logic             accept;

    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign funct7   = instr[31:25];
    assign funct3   = instr[14:12];
    assign rs2      = instr[24:20];
    assign rd       = instr[11:7];
    assign pc       = instr_pc;
    assign pc4      = instr_pc + `XLEN'(4);
    assign data1    = rs1_data;
    assign data2    = rs2_data;

    assign imm_i = {{(`XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{(`XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{(`XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    // which operands and immediate each opcode actually uses
    always_comb begin
        op_dec    = NOP_OP;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        writes_rd = 1'b0;
        imm       = '0;
        case (instr[6:0])
            OP: begin
                op_dec    = OP;
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                writes_rd = 1'b1;
            end
            OP_IMM: begin
                op_dec    = OP_IMM;
                uses_rs1  = 1'b1;
                writes_rd = 1'b1;
                imm       = imm_i;
            end
            LUI, AUIPC: begin
                op_dec    = opcode_e'(instr[6:0]);
                writes_rd = 1'b1;
                imm       = imm_u;
            end
            BRANCH: begin
                op_dec   = BRANCH;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                imm      = imm_b;
            end
            JAL: begin
                op_dec    = JAL;
                writes_rd = 1'b1;
                imm       = imm_j;
            end
            default: ;
        endcase
    end

    // raw hazard against the writer in ID/EX or in EX/WB
    assign rs1_busy = uses_rs1 && (rs1_addr != '0) &&
                      ((!ex_wr_n && (ex_rd == rs1_addr)) || (wb_valid && (wb_rd == rs1_addr)));
    assign rs2_busy = uses_rs2 && (rs2_addr != '0) &&
                      ((!ex_wr_n && (ex_rd == rs2_addr)) || (wb_valid && (wb_rd == rs2_addr)));

    // a wrong-path instruction is dropped, so it never has to wait
    assign squash      = redirect || squash_q;
    assign interlock   = instr_valid && (rs1_busy || rs2_busy) && !squash;
    assign instr_ready = !stall && !interlock;
    assign accept      = instr_valid && instr_ready;

    // remember a redirect whose wrong-path instruction was held back by stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            squash_q <= 1'b0;
        end else if (accept) begin
            squash_q <= 1'b0;
        end else if (redirect && instr_valid) begin
            squash_q <= 1'b1;
        end
    end

    assign opcode   = (instr_valid && !squash) ? op_dec : NOP_OP;
    assign wr_reg_n = !(instr_valid && !squash && writes_rd);

endmodule

/* verilog/id_ex_regs.sv */
`timescale 1ns/1ns
`include "rv_pipe_defines.svh"

module id_ex_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,
    input  logic                 interlock,

    input  logic [`XLEN-1:0]     pc_in,
    output logic [`XLEN-1:0]     pc_out,
    input  logic [`XLEN-1:0]     pc4_in,
    output logic [`XLEN-1:0]     pc4_out,
    input  logic [`XLEN-1:0]     data1_in,
    input  logic [`XLEN-1:0]     data2_in,
    output logic [`XLEN-1:0]     data1_out,
    output logic [`XLEN-1:0]     data2_out,
    input  logic [6:0]           funct7_in,
    output logic [6:0]           funct7_out,
    input  logic [2:0]           funct3_in,
    output logic [2:0]           funct3_out,
    input  logic [`REG_AW-1:0]   rs2_in,
    output logic [`REG_AW-1:0]   rs2_out,
    input  logic [`REG_AW-1:0]   rd_in,
    output logic [`REG_AW-1:0]   rd_out,
    input  rv_pipe_pkg::opcode_e opcode_in,
    output rv_pipe_pkg::opcode_e opcode_out,
    input  logic [`XLEN-1:0]     imm_in,
    output logic [`XLEN-1:0]     imm_out,
    input  logic                 wr_reg_n_in,
    output logic                 wr_reg_n_out
);
    import rv_pipe_pkg::*;

    logic bubble;

    // stall and interlock both turn the next execute cycle into a bubble
    assign bubble = stall || interlock;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_out       <= '0;
            pc4_out      <= '0;
            data1_out    <= '0;
            data2_out    <= '0;
            funct7_out   <= '0;
            funct3_out   <= '0;
            rs2_out      <= '0;
            rd_out       <= '0;
            opcode_out   <= NOP_OP;
            imm_out      <= '0;
            wr_reg_n_out <= 1'b1;
        end else if (bubble) begin
            pc_out       <= '0;
            pc4_out      <= '0;
            data1_out    <= '0;
            data2_out    <= '0;
            funct7_out   <= '0;
            funct3_out   <= '0;
            rs2_out      <= '0;
            rd_out       <= '0;
            opcode_out   <= NOP_OP;
            imm_out      <= '0;
            // no register write for a bubble
            wr_reg_n_out <= 1'b1;
        end else begin
            pc_out       <= pc_in;
            pc4_out      <= pc4_in;
            data1_out    <= data1_in;
            data2_out    <= data2_in;
            funct7_out   <= funct7_in;
            funct3_out   <= funct3_in;
            rs2_out      <= rs2_in;
            rd_out       <= rd_in;
            opcode_out   <= opcode_in;
            imm_out      <= imm_in;
            wr_reg_n_out <= wr_reg_n_in;
        end
    end

endmodule

/* verilog/rv_execute.sv */
`timescale 1ns/1ns
`include "rv_pipe_defines.svh"

module rv_execute (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [`XLEN-1:0]     pc,
    input  logic [`XLEN-1:0]     pc4,
    input  logic [`XLEN-1:0]     data1,
    input  logic [`XLEN-1:0]     data2,
    input  logic [6:0]           funct7,
    input  logic [2:0]           funct3,
    input  logic [`REG_AW-1:0]   rd,
    input  rv_pipe_pkg::opcode_e opcode,
    input  logic [`XLEN-1:0]     imm,
    input  logic                 wr_reg_n,
    output logic                 wb_valid,
    output logic [`REG_AW-1:0]   wb_rd,
    output logic [`XLEN-1:0]     wb_data,
    output logic                 redirect,
    output logic [`XLEN-1:0]     redirect_pc,
    output logic [`REG_AW-1:0]   ex_rd,
    output logic                 ex_wr_n
);
    import rv_pipe_pkg::*;

    localparam int SHW = $clog2(`XLEN);

    alu_op_e          alu_op;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_res;
    logic [`XLEN-1:0] result;
    logic             taken;

    always_comb begin
        alu_op = ADD;
        if ((opcode == OP) || (opcode == OP_IMM)) begin
            case (funct3)
                // funct7[5] selects sub, register form only
                3'b000:  alu_op = ((opcode == OP) && funct7[5]) ? SUB : ADD;
                3'b001:  alu_op = SLL;
                3'b010:  alu_op = SLT;
                3'b100:  alu_op = XOR;
                3'b101:  alu_op = SRL;
                3'b110:  alu_op = OR;
                3'b111:  alu_op = AND;
                default: alu_op = ADD;
            endcase
        end else if (opcode == LUI) begin
            alu_op = PASS_B;
        end
    end

    // auipc adds to pc and everything but OP takes the immediate
    assign op_a = (opcode == AUIPC) ? pc : data1;
    assign op_b = (opcode == OP) ? data2 : imm;

    always_comb begin
        case (alu_op)
            ADD:     alu_res = op_a + op_b;
            SUB:     alu_res = op_a - op_b;
            AND:     alu_res = op_a & op_b;
            OR:      alu_res = op_a | op_b;
            XOR:     alu_res = op_a ^ op_b;
            SLT:     alu_res = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            SLL:     alu_res = op_a << op_b[SHW-1:0];
            SRL:     alu_res = op_a >> op_b[SHW-1:0];
            default: alu_res = op_b;
        endcase
    end

    // jal links the return address
    assign result = (opcode == JAL) ? pc4 : alu_res;

    always_comb begin
        case (funct3)
            3'b000:  taken = (data1 == data2);
            3'b001:  taken = (data1 != data2);
            3'b100:  taken = $signed(data1) < $signed(data2);
            3'b101:  taken = $signed(data1) >= $signed(data2);
            default: taken = 1'b0;
        endcase
    end

    assign redirect    = ((opcode == BRANCH) && taken) || (opcode == JAL);
    assign redirect_pc = pc + imm;

    // hazard view of the instruction now in EX
    assign ex_rd   = rd;
    assign ex_wr_n = wr_reg_n;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= !wr_reg_n && (rd != '0);
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= rd;
        wb_data <= result;
    end

endmodule

/* verilog/rv_pipe_top.sv */
`timescale 1ns/1ns
`include "rv_pipe_defines.svh"

module rv_pipe_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               instr_valid,
    input  logic [`XLEN-1:0]   instr,
    input  logic [`XLEN-1:0]   instr_pc,
    input  logic               stall,
    output logic               instr_ready,
    output logic               wb_valid,
    output logic [`REG_AW-1:0] wb_rd,
    output logic [`XLEN-1:0]   wb_data,
    output logic               redirect,
    output logic [`XLEN-1:0]   redirect_pc
);
    import rv_pipe_pkg::*;

    logic [`REG_AW-1:0] rs1_addr, rs2_addr;
    logic [`XLEN-1:0]   rs1_data, rs2_data;
    logic               interlock;

    // decode side of the ID/EX register
    logic [`XLEN-1:0]   id_pc, id_pc4, id_data1, id_data2, id_imm;
    logic [6:0]         id_funct7;
    logic [2:0]         id_funct3;
    logic [`REG_AW-1:0] id_rs2, id_rd;
    opcode_e            id_opcode;
    logic               id_wr_reg_n;

    // execute side of the ID/EX register
    logic [`XLEN-1:0]   ex_pc, ex_pc4, ex_data1, ex_data2, ex_imm;
    logic [6:0]         ex_funct7;
    logic [2:0]         ex_funct3;
    logic [`REG_AW-1:0] ex_rd_q;
    opcode_e            ex_opcode;
    logic               ex_wr_reg_n;

    // instruction in EX, as seen by the hazard check
    logic [`REG_AW-1:0] ex_rd;
    logic               ex_wr_n;

    rv_regfile rv_regfile_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wb_valid),
        .wr_addr  (wb_rd),
        .wr_data  (wb_data)
    );

    rv_decode rv_decode_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .stall       (stall),
        .redirect    (redirect),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .ex_rd       (ex_rd),
        .ex_wr_n     (ex_wr_n),
        .wb_rd       (wb_rd),
        .wb_valid    (wb_valid),
        .instr_ready (instr_ready),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .interlock   (interlock),
        .pc          (id_pc),
        .pc4         (id_pc4),
        .data1       (id_data1),
        .data2       (id_data2),
        .funct7      (id_funct7),
        .funct3      (id_funct3),
        .rs2         (id_rs2),
        .rd          (id_rd),
        .opcode      (id_opcode),
        .imm         (id_imm),
        .wr_reg_n    (id_wr_reg_n)
    );

    id_ex_regs id_ex_regs_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .interlock   (interlock),
        .pc_in       (id_pc),       .pc_out       (ex_pc),
        .pc4_in      (id_pc4),      .pc4_out      (ex_pc4),
        .data1_in    (id_data1),    .data1_out    (ex_data1),
        .data2_in    (id_data2),    .data2_out    (ex_data2),
        .funct7_in   (id_funct7),   .funct7_out   (ex_funct7),
        .funct3_in   (id_funct3),   .funct3_out   (ex_funct3),
        .rs2_in      (id_rs2),      .rs2_out      (),
        .rd_in       (id_rd),       .rd_out       (ex_rd_q),
        .opcode_in   (id_opcode),   .opcode_out   (ex_opcode),
        .imm_in      (id_imm),      .imm_out      (ex_imm),
        .wr_reg_n_in (id_wr_reg_n), .wr_reg_n_out (ex_wr_reg_n)
    );

    rv_execute rv_execute_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .pc          (ex_pc),
        .pc4         (ex_pc4),
        .data1       (ex_data1),
        .data2       (ex_data2),
        .funct7      (ex_funct7),
        .funct3      (ex_funct3),
        .rd          (ex_rd_q),
        .opcode      (ex_opcode),
        .imm         (ex_imm),
        .wr_reg_n    (ex_wr_reg_n),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .ex_rd       (ex_rd),
        .ex_wr_n     (ex_wr_n)
    );

endmodule

/* bench/rv_pipe_assert.sv */
`timescale 1ns/1ns

module rv_pipe_assert (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 instr_ready,
    input logic                 interlock,
    input logic                 wb_valid,
    input logic                 redirect,
    input rv_pipe_pkg::opcode_e ex_opcode,
    input logic                 ex_wr_reg_n
);
    import rv_pipe_pkg::*;

    // number of failed assertions so far
    int unsigned fail_count = 0;

    // pipeline leaves reset idle and ready
    reset_idle: assert property (@(posedge clk)
        $rose(rst_n) |-> !wb_valid && !redirect && instr_ready)
        else begin
            fail_count++;
            $error("outputs not idle after reset release");
        end

    interlock_holds: assert property (@(posedge clk) disable iff (!rst_n)
        interlock |-> !instr_ready)
        else begin
            fail_count++;
            $error("instr_ready high during interlock");
        end

    // a bubble in EX never reaches writeback
    bubble_no_wb: assert property (@(posedge clk) disable iff (!rst_n)
        (ex_opcode == NOP_OP) |=> !wb_valid)
        else begin
            fail_count++;
            $error("writeback after a bubble in EX");
        end

    redirect_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |=> !redirect)
        else begin
            fail_count++;
            $error("redirect held for more than one cycle");
        end

    // the wrong-path instruction is squashed into a bubble
    redirect_squash: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |=> ex_wr_reg_n && (ex_opcode == NOP_OP))
        else begin
            fail_count++;
            $error("instruction behind a redirect was not squashed");
        end

endmodule

bind rv_pipe_top rv_pipe_assert rv_pipe_assert_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_ready (instr_ready),
    .interlock   (interlock),
    .wb_valid    (wb_valid),
    .redirect    (redirect),
    .ex_opcode   (ex_opcode),
    .ex_wr_reg_n (ex_wr_reg_n)
);

/* bench/rv_pipe_tb.sv */
`timescale 1ns/1ns
`include "rv_pipe_defines.svh"

module rv_pipe_tb;
    import rv_pipe_pkg::*;

    // one program entry, with the fields the reference model works from
    typedef struct packed {
        logic [`XLEN-1:0]   word;
        logic [`XLEN-1:0]   pc;
        opcode_e            opc;
        logic [2:0]         f3;
        logic               sub;
        logic [`REG_AW-1:0] rd;
        logic [`REG_AW-1:0] rs1;
        logic [`REG_AW-1:0] rs2;
        logic [`XLEN-1:0]   imm;
    } instr_t;

    logic               clk;
    logic               rst_n;
    logic               instr_valid;
    logic [`XLEN-1:0]   instr;
    logic [`XLEN-1:0]   instr_pc;
    logic               stall;
    logic               instr_ready;
    logic               wb_valid;
    logic [`REG_AW-1:0] wb_rd;
    logic [`XLEN-1:0]   wb_data;
    logic               redirect;
    logic [`XLEN-1:0]   redirect_pc;

    instr_t             prog[$];
    logic [`XLEN-1:0]   ref_regs[`NUM_REGS];
    logic [`REG_AW-1:0] exp_rd[$];
    logic [`XLEN-1:0]   exp_data[$];
    logic [`XLEN-1:0]   exp_target[$];
    logic               squash_next;
    logic [`XLEN-1:0]   next_pc;
    int                 watchdog_cycles = 0;

    rv_pipe_top rv_pipe_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .stall       (stall),
        .instr_ready (instr_ready),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [`XLEN-1:0] expected,
                               input logic [`XLEN-1:0] actual);
        assert (actual === expected) else begin
            fail_run($sformatf("CHECK FAILED at %0t: %s expected %h, got %h",
                               $time, name, expected, actual));
        end
    endtask

    function automatic void append_instr(input logic [`XLEN-1:0] word, input opcode_e opc,
            input logic [2:0] f3, input logic sub, input logic [`REG_AW-1:0] rd,
            input logic [`REG_AW-1:0] rs1, input logic [`REG_AW-1:0] rs2,
            input logic [`XLEN-1:0] imm);
        instr_t e;
        e = '{word, next_pc, opc, f3, sub, rd, rs1, rs2, imm};
        prog.push_back(e);
        next_pc = next_pc + 32'd4;
    endfunction

    function automatic void reg_op(input logic [2:0] f3, input logic sub,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
        append_instr({(sub ? 7'h20 : 7'h00), rs2, rs1, f3, rd, OP}, OP, f3, sub,
                     rd, rs1, rs2, '0);
    endfunction

    function automatic void imm_op(input logic [2:0] f3, input logic [4:0] rd,
            input logic [4:0] rs1, input logic [11:0] imm12);
        append_instr({imm12, rs1, f3, rd, OP_IMM}, OP_IMM, f3, 1'b0, rd, rs1, 5'd0,
                     {{20{imm12[11]}}, imm12});
    endfunction

    function automatic void upper_op(input opcode_e opc, input logic [4:0] rd,
            input logic [19:0] hi20);
        append_instr({hi20, rd, opc}, opc, 3'b000, 1'b0, rd, 5'd0, 5'd0, {hi20, 12'b0});
    endfunction

    function automatic void branch_op(input logic [2:0] f3, input logic [4:0] rs1,
            input logic [4:0] rs2, input logic [12:0] off);
        append_instr({off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], BRANCH},
                     BRANCH, f3, 1'b0, 5'd0, rs1, rs2, {{19{off[12]}}, off});
    endfunction

    function automatic void jump_link(input logic [4:0] rd, input logic [20:0] off);
        append_instr({off[20], off[10:1], off[11], off[19:12], rd, JAL}, JAL, 3'b000, 1'b0,
                     rd, 5'd0, 5'd0, {{11{off[20]}}, off});
    endfunction

    task automatic build_program();
        logic [31:0] r;
        // random constants in x1..x8, each addi waits on its own lui
        for (int k = 1; k <= 8; k++) begin
            r = $urandom;
            upper_op(LUI, 5'(k), r[31:12]);
            imm_op(3'b000, 5'(k), 5'(k), r[11:0]);
        end
        reg_op(3'b000, 1'b0, 5'd10, 5'd1, 5'd2);
        reg_op(3'b000, 1'b1, 5'd11, 5'd10, 5'd3);
        reg_op(3'b111, 1'b0, 5'd12, 5'd4, 5'd5);
        reg_op(3'b110, 1'b0, 5'd13, 5'd12, 5'd6);
        reg_op(3'b100, 1'b0, 5'd14, 5'd7, 5'd8);
        reg_op(3'b010, 1'b0, 5'd15, 5'd1, 5'd2);
        reg_op(3'b001, 1'b0, 5'd16, 5'd3, 5'd4);
        reg_op(3'b101, 1'b0, 5'd17, 5'd5, 5'd16);
        imm_op(3'b000, 5'd18, 5'd17, 12'hf85);
        imm_op(3'b111, 5'd19, 5'd1, 12'h0f0);
        imm_op(3'b110, 5'd20, 5'd2, 12'h80f);
        imm_op(3'b100, 5'd21, 5'd3, 12'hfff);
        imm_op(3'b010, 5'd22, 5'd4, 12'h7ff);
        upper_op(AUIPC, 5'd23, 20'h00012);
        // results aimed at x0 must vanish
        reg_op(3'b000, 1'b0, 5'd0, 5'd1, 5'd2);
        imm_op(3'b000, 5'd0, 5'd0, 12'd5);
        // each branch and jal is followed by a wrong-path addi to x9
        imm_op(3'b000, 5'd24, 5'd0, 12'hffd);
        imm_op(3'b000, 5'd25, 5'd0, 12'd2);
        branch_op(3'b000, 5'd1, 5'd1, 13'd16);
        imm_op(3'b000, 5'd9, 5'd0, 12'd77);
        branch_op(3'b001, 5'd1, 5'd1, 13'd16);
        imm_op(3'b000, 5'd9, 5'd0, 12'd55);
        branch_op(3'b100, 5'd24, 5'd25, 13'h1ff8);
        imm_op(3'b000, 5'd9, 5'd0, 12'd66);
        branch_op(3'b101, 5'd24, 5'd25, 13'd12);
        imm_op(3'b000, 5'd9, 5'd0, 12'd44);
        branch_op(3'b101, 5'd25, 5'd24, 13'd20);
        imm_op(3'b000, 5'd9, 5'd0, 12'd33);
        jump_link(5'd26, 21'd40);
        imm_op(3'b000, 5'd9, 5'd0, 12'd22);
        reg_op(3'b000, 1'b0, 5'd27, 5'd26, 5'd9);
        repeat (3) append_instr(`NOP_INSTR, OP_IMM, 3'b000, 1'b0, 5'd0, 5'd0, 5'd0, '0);
    endtask

    // in-order ISA model, run as each instruction is accepted
    task automatic model_retire(input instr_t e);
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] res;
        logic             taken;
        if (squash_next) begin
            squash_next = 1'b0;
            return;
        end
        a = ref_regs[e.rs1];
        b = (e.opc == OP || e.opc == BRANCH) ? ref_regs[e.rs2] : e.imm;
        taken = 1'b0;
        res = '0;
        case (e.opc)
            LUI:    res = e.imm;
            AUIPC:  res = e.pc + e.imm;
            JAL:    res = e.pc + 32'd4;
            BRANCH: begin
                case (e.f3)
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    default: taken = ($signed(a) >= $signed(b));
                endcase
            end
            default: begin
                case (e.f3)
                    3'b000:  res = e.sub ? a - b : a + b;
                    3'b001:  res = a << b[4:0];
                    3'b010:  res = {31'b0, $signed(a) < $signed(b)};
                    3'b100:  res = a ^ b;
                    3'b101:  res = a >> b[4:0];
                    3'b110:  res = a | b;
                    default: res = a & b;
                endcase
            end
        endcase
        if (taken || e.opc == JAL) begin
            exp_target.push_back(e.pc + e.imm);
            squash_next = 1'b1;
        end
        if (e.opc != BRANCH && e.rd != '0) begin
            ref_regs[e.rd] = res;
            exp_rd.push_back(e.rd);
            exp_data.push_back(res);
        end
    endtask

    task automatic issue_program();
        foreach (prog[i]) begin
            // hold the instruction until a rising edge sees it accepted
            do begin
                @(negedge clk);
                instr_valid = 1'b1;
                instr       = prog[i].word;
                instr_pc    = prog[i].pc;
                stall       = ($urandom_range(3, 0) == 0);
                @(posedge clk);
            end while (!instr_ready);
            model_retire(prog[i]);
        end
        @(negedge clk);
        instr_valid = 1'b0;
        stall       = 1'b0;
    endtask

    always @(negedge clk) begin
        if (rv_pipe_top_inst.rv_pipe_assert_inst.fail_count != 0) begin
            fail_run("a pipeline protocol assertion failed");
        end
    end

    always @(negedge clk) begin
        if (rst_n && wb_valid) begin
            if (exp_rd.size() == 0) begin
                fail_run("writeback seen while no write was expected");
            end else begin
                check_value("wb_rd", exp_rd.pop_front(), wb_rd);
                check_value("wb_data", exp_data.pop_front(), wb_data);
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n && redirect) begin
            if (exp_target.size() == 0) begin
                fail_run("redirect raised without a taken branch or jal");
            end else begin
                check_value("redirect_pc", exp_target.pop_front(), redirect_pc);
            end
        end
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        fail_run("watchdog expired before the program drained");
    end

    initial begin
        void'($urandom(32'h55c5));
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = `NOP_INSTR;
        instr_pc    = '0;
        stall       = 1'b0;
        squash_next = 1'b0;
        next_pc     = 32'h0000_1000;
        foreach (ref_regs[i]) begin
            ref_regs[i] = '0;
        end
        build_program();
        watchdog_cycles = prog.size() * 40 + 10;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        issue_program();
        // last writeback lands two edges after the final accept
        repeat (8) @(negedge clk);
        if (exp_rd.size() == 0 && exp_target.size() == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            fail_run("program ended with writebacks or redirects still missing");
        end
    end

endmodule

/* rv_pipe_top.f */
+incdir+include
verilog/rv_pipe_pkg.sv
verilog/rv_regfile.sv
verilog/rv_decode.sv
verilog/id_ex_regs.sv
verilog/rv_execute.sv
verilog/rv_pipe_top.sv
bench/rv_pipe_assert.sv
bench/rv_pipe_tb.sv

/* Bender.yml */
package:
  name: rv_pipe

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/rv_pipe_pkg.sv
      - verilog/rv_regfile.sv
      - verilog/rv_decode.sv
      - verilog/id_ex_regs.sv
      - verilog/rv_execute.sv
      - verilog/rv_pipe_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/rv_pipe_assert.sv
      - bench/rv_pipe_tb.sv
